/* exu_defs.svh */
`ifndef EXU_DEFS_SVH
`define EXU_DEFS_SVH

// integer datapath, rv64
`define EXU_XLEN      64

// register file shape
`define EXU_REG_AW    5
`define EXU_NUM_REGS  32

// load/store bus
`define EXU_ADDR_W    32
`define EXU_STRB_W    8
`define EXU_RESP_W    2

// any other response code means retry
`define EXU_RESP_OKAY 2'b00

`endif

/* exu_pkg.sv */
package exu_pkg;

    // decoded instruction from the upstream decoder
    // nop keeps the stage idle and holds pc
    typedef enum logic [5:0] {
        OP_NOP,
        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
        OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU,
        OP_ADDI, OP_LUI, OP_AUIPC,
        OP_JAL, OP_JALR,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_LB, OP_LH, OP_LW, OP_LD, OP_LBU, OP_LHU, OP_LWU,
        OP_SB, OP_SH, OP_SW, OP_SD
    } exu_op_t;

    // alu function
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
    } alu_op_t;

    // how the next pc is formed
    typedef enum logic [3:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_JAL, BR_JALR
    } br_cond_t;

    typedef enum logic [1:0] {MEM_NONE, MEM_LOAD, MEM_STORE} mem_kind_t;

    // byte, half, word, double
    typedef enum logic [1:0] {SZ_B, SZ_H, SZ_W, SZ_D} mem_size_t;

    // register writeback source
    typedef enum logic [1:0] {WB_NONE, WB_ALU, WB_LINK, WB_LOAD} wb_sel_t;

endpackage

/* exu_decode.sv */
`timescale 1ns/1ps
`include "exu_defs.svh"

module exu_decode import exu_pkg::*; (
    input  exu_op_t              opcode,
    input  logic [`EXU_XLEN-1:0] pc,
    input  logic [`EXU_XLEN-1:0] imm,
    input  logic [`EXU_XLEN-1:0] src1,
    input  logic [`EXU_XLEN-1:0] src2,
    output logic [`EXU_XLEN-1:0] operand_a,
    output logic [`EXU_XLEN-1:0] operand_b,
    output alu_op_t              alu_op,
    output br_cond_t             br_cond,
    output mem_kind_t            mem_kind,
    output mem_size_t            mem_size,
    output logic                 mem_unsigned,
    output wb_sel_t              wb_sel,
    output logic                 op_valid
);

    // first alu operand source
    typedef enum logic [1:0] {A_SRC1, A_PC, A_ZERO} a_sel_t;

    // one row of the control table
    typedef struct packed {
        alu_op_t   alu;
        br_cond_t  br;
        mem_kind_t mem;
        mem_size_t size;
        logic      uns;
        wb_sel_t   wb;
        a_sel_t    a_sel;
        logic      b_imm;
    } ctrl_t;

    ctrl_t ctrl;

    // fields: alu, next pc, mem kind, size, unsigned, writeback, operand a, imm as b
    always_comb begin
        case (opcode)
            OP_ADD:   ctrl = '{ALU_ADD,  BR_NONE, MEM_NONE,  SZ_D, 1'b0, WB_ALU,  A_SRC1, 1'b0};
            OP_SUB:   ctrl = '{ALU_SUB,  BR_NONE, MEM_NONE,  SZ_D, 1'b0, WB_ALU,  A_SRC1, 1'b0};
            OP_AND:   ctrl = '{ALU_AND,  BR_NONE, MEM_NONE,  SZ_D, 1'b0, WB_ALU,  A_SRC1, 1'b0};
            OP_OR:    ctrl = '{ALU_OR,   BR_NONE, MEM_NONE,  SZ_D, 1'b0, WB_ALU,  A_SRC1, 1'b0};
            OP_XOR:   ctrl = '{ALU_XOR,  BR_NONE, MEM_NONE,  SZ_D, 1'b0, WB_ALU,  A_SRC1, 1'b0};
            OP_SLL:   ctrl = '{ALU_SLL,  BR_NONE, MEM_NONE,  SZ_D, 1'b0, WB_ALU,  A_SRC1, 1'b0};
            OP_SRL:   ctrl = '{ALU_SRL,  BR_NONE, MEM_NONE,  SZ_D, 1'b0, WB_ALU,  A_SRC1, 1'b0};
            OP_SRA:   ctrl = '{ALU_SRA,  BR_NONE, MEM_NONE,  SZ_D, 1'b0, WB_ALU,  A_SRC1, 1'b0};
            OP_SLT:   ctrl = '{ALU_SLT,  BR_NONE, MEM_NONE,  SZ_D, 1'b0, WB_ALU,  A_SRC1, 1'b0};
            OP_SLTU:  ctrl = '{ALU_SLTU, BR_NONE, MEM_NONE,  SZ_D, 1'b0, WB_ALU,  A_SRC1, 1'b0};
            OP_ADDI:  ctrl = '{ALU_ADD,  BR_NONE, MEM_NONE,  SZ_D, 1'b0, WB_ALU,  A_SRC1, 1'b1};
            // lui is 0 + imm, the decoder already placed imm in the upper bits
            OP_LUI:   ctrl = '{ALU_ADD,  BR_NONE, MEM_NONE,  SZ_D, 1'b0, WB_ALU,  A_ZERO, 1'b1};
            OP_AUIPC: ctrl = '{ALU_ADD,  BR_NONE, MEM_NONE,  SZ_D, 1'b0, WB_ALU,  A_PC,   1'b1};
            // jump targets come out of the alu adder
            OP_JAL:   ctrl = '{ALU_ADD,  BR_JAL,  MEM_NONE,  SZ_D, 1'b0, WB_LINK, A_PC,   1'b1};
            OP_JALR:  ctrl = '{ALU_ADD,  BR_JALR, MEM_NONE,  SZ_D, 1'b0, WB_LINK, A_SRC1, 1'b1};
            // branches compare src1/src2 directly, alu result unused
            OP_BEQ:   ctrl = '{ALU_SUB,  BR_EQ,   MEM_NONE,  SZ_D, 1'b0, WB_NONE, A_SRC1, 1'b0};
            OP_BNE:   ctrl = '{ALU_SUB,  BR_NE,   MEM_NONE,  SZ_D, 1'b0, WB_NONE, A_SRC1, 1'b0};
            OP_BLT:   ctrl = '{ALU_SUB,  BR_LT,   MEM_NONE,  SZ_D, 1'b0, WB_NONE, A_SRC1, 1'b0};
            OP_BGE:   ctrl = '{ALU_SUB,  BR_GE,   MEM_NONE,  SZ_D, 1'b0, WB_NONE, A_SRC1, 1'b0};
            OP_BLTU:  ctrl = '{ALU_SUB,  BR_LTU,  MEM_NONE,  SZ_D, 1'b0, WB_NONE, A_SRC1, 1'b0};
            OP_BGEU:  ctrl = '{ALU_SUB,  BR_GEU,  MEM_NONE,  SZ_D, 1'b0, WB_NONE, A_SRC1, 1'b0};
            // address is src1 + imm for every memory access
            OP_LB:    ctrl = '{ALU_ADD,  BR_NONE, MEM_LOAD,  SZ_B, 1'b0, WB_LOAD, A_SRC1, 1'b1};
            OP_LH:    ctrl = '{ALU_ADD,  BR_NONE, MEM_LOAD,  SZ_H, 1'b0, WB_LOAD, A_SRC1, 1'b1};
            OP_LW:    ctrl = '{ALU_ADD,  BR_NONE, MEM_LOAD,  SZ_W, 1'b0, WB_LOAD, A_SRC1, 1'b1};
            OP_LD:    ctrl = '{ALU_ADD,  BR_NONE, MEM_LOAD,  SZ_D, 1'b0, WB_LOAD, A_SRC1, 1'b1};
            OP_LBU:   ctrl = '{ALU_ADD,  BR_NONE, MEM_LOAD,  SZ_B, 1'b1, WB_LOAD, A_SRC1, 1'b1};
            OP_LHU:   ctrl = '{ALU_ADD,  BR_NONE, MEM_LOAD,  SZ_H, 1'b1, WB_LOAD, A_SRC1, 1'b1};
            OP_LWU:   ctrl = '{ALU_ADD,  BR_NONE, MEM_LOAD,  SZ_W, 1'b1, WB_LOAD, A_SRC1, 1'b1};
            OP_SB:    ctrl = '{ALU_ADD,  BR_NONE, MEM_STORE, SZ_B, 1'b0, WB_NONE, A_SRC1, 1'b1};
            OP_SH:    ctrl = '{ALU_ADD,  BR_NONE, MEM_STORE, SZ_H, 1'b0, WB_NONE, A_SRC1, 1'b1};
            OP_SW:    ctrl = '{ALU_ADD,  BR_NONE, MEM_STORE, SZ_W, 1'b0, WB_NONE, A_SRC1, 1'b1};
            OP_SD:    ctrl = '{ALU_ADD,  BR_NONE, MEM_STORE, SZ_D, 1'b0, WB_NONE, A_SRC1, 1'b1};
            // nop: no write, no access, falls through to pc+4
            default:  ctrl = '{ALU_ADD,  BR_NONE, MEM_NONE,  SZ_D, 1'b0, WB_NONE, A_SRC1, 1'b0};
        endcase
    end

    always_comb begin
        case (ctrl.a_sel)
            A_PC:    operand_a = pc;
            A_ZERO:  operand_a = '0;
            default: operand_a = src1;
        endcase
    end

    // i/u/j/s formats take imm, r and b formats take src2
    assign operand_b    = ctrl.b_imm ? imm : src2;
    assign alu_op       = ctrl.alu;
    assign br_cond      = ctrl.br;
    assign mem_kind     = ctrl.mem;
    assign mem_size     = ctrl.size;
    assign mem_unsigned = ctrl.uns;
    assign wb_sel       = ctrl.wb;
    assign op_valid     = opcode != OP_NOP;

endmodule

/* exu_regfile.sv */
`timescale 1ns/1ps
`include "exu_defs.svh"

module exu_regfile import exu_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`EXU_REG_AW-1:0] rs1,
    input  logic [`EXU_REG_AW-1:0] rs2,
    input  logic [`EXU_REG_AW-1:0] rd,
    input  wb_sel_t                wb_sel,
    input  logic [`EXU_XLEN-1:0]   alu_result,
    input  logic [`EXU_XLEN-1:0]   link,
    input  logic [`EXU_XLEN-1:0]   load_data,
    input  logic                   load_done,
    output logic [`EXU_XLEN-1:0]   src1,
    output logic [`EXU_XLEN-1:0]   src2
);

    logic [`EXU_XLEN-1:0] regs [`EXU_NUM_REGS];
    logic [`EXU_XLEN-1:0] wdata;
    logic                 wen;

    // writeback source select
    // loads only write in the lsu done cycle
    always_comb begin
        case (wb_sel)
            WB_ALU:  wdata = alu_result;
            WB_LINK: wdata = link;
            default: wdata = load_data;
        endcase
    end

    assign wen = (wb_sel == WB_ALU) || (wb_sel == WB_LINK) || (wb_sel == WB_LOAD && load_done);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `EXU_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    // x0 reads as zero
    assign src1 = (rs1 == '0) ? '0 : regs[rs1];
    assign src2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* exu_alu_branch.sv */
`timescale 1ns/1ps
`include "exu_defs.svh"

module exu_alu_branch import exu_pkg::*; (
    input  logic [`EXU_XLEN-1:0] pc,
    input  logic [`EXU_XLEN-1:0] imm,
    input  logic [`EXU_XLEN-1:0] src1,
    input  logic [`EXU_XLEN-1:0] src2,
    input  logic [`EXU_XLEN-1:0] operand_a,
    input  logic [`EXU_XLEN-1:0] operand_b,
    input  alu_op_t              alu_op,
    input  br_cond_t             br_cond,
    output logic [`EXU_XLEN-1:0] alu_result,
    output logic [`EXU_XLEN-1:0] link,
    output logic [`EXU_XLEN-1:0] dnpc
);

    logic [5:0] shamt;
    logic       lt_s;
    logic       lt_u;
    logic       taken;

    // rv64 shift amount is 6 bits
    assign shamt = operand_b[5:0];
    assign lt_s  = $signed(operand_a) < $signed(operand_b);
    assign lt_u  = operand_a < operand_b;

    always_comb begin
        case (alu_op)
            ALU_SUB:  alu_result = operand_a - operand_b;
            ALU_AND:  alu_result = operand_a & operand_b;
            ALU_OR:   alu_result = operand_a | operand_b;
            ALU_XOR:  alu_result = operand_a ^ operand_b;
            ALU_SLL:  alu_result = operand_a << shamt;
            ALU_SRL:  alu_result = operand_a >> shamt;
            ALU_SRA:  alu_result = $signed(operand_a) >>> shamt;
            ALU_SLT:  alu_result = {{(`EXU_XLEN-1){1'b0}}, lt_s};
            ALU_SLTU: alu_result = {{(`EXU_XLEN-1){1'b0}}, lt_u};
            default:  alu_result = operand_a + operand_b;
        endcase
    end

    // branch compare on the raw register values
    always_comb begin
        case (br_cond)
            BR_EQ:   taken = src1 == src2;
            BR_NE:   taken = src1 != src2;
            BR_LT:   taken = $signed(src1) < $signed(src2);
            BR_GE:   taken = $signed(src1) >= $signed(src2);
            BR_LTU:  taken = src1 < src2;
            BR_GEU:  taken = src1 >= src2;
            default: taken = 1'b0;
        endcase
    end

    // sequential pc, also the jal/jalr link value
    assign link = pc + `EXU_XLEN'(4);

    always_comb begin
        case (br_cond)
            BR_JAL:  dnpc = alu_result;
            // jalr target has bit 0 forced low
            BR_JALR: dnpc = {alu_result[`EXU_XLEN-1:1], 1'b0};
            default: dnpc = taken ? pc + imm : link;
        endcase
    end

endmodule

/* exu_lsu.sv */
`timescale 1ns/1ps
`include "exu_defs.svh"

module exu_lsu import exu_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  mem_kind_t              mem_kind,
    input  mem_size_t              mem_size,
    input  logic                   mem_unsigned,
    input  logic                   op_valid,
    input  logic [`EXU_XLEN-1:0]   alu_result,
    input  logic [`EXU_XLEN-1:0]   src2,
    output logic                   arvalid,
    output logic [`EXU_ADDR_W-1:0] araddr,
    input  logic                   arready,
    input  logic                   rvalid,
    input  logic [`EXU_XLEN-1:0]   rrdata,
    input  logic [`EXU_RESP_W-1:0] rresp,
    output logic                   rready,
    output logic                   awvalid,
    output logic [`EXU_ADDR_W-1:0] awaddr,
    input  logic                   awready,
    output logic                   wvalid,
    output logic [`EXU_XLEN-1:0]   wwdata,
    output logic [`EXU_STRB_W-1:0] wstrb,
    input  logic                   wready,
    input  logic                   bvalid,
    input  logic [`EXU_RESP_W-1:0] bresp,
    output logic                   bready,
    output logic [`EXU_XLEN-1:0]   load_data,
    output logic                   load_done,
    output logic                   pc_update,
    output logic                   exu_block
);

    typedef enum logic [1:0] {LS_IDLE, LS_REQ, LS_WAIT, LS_DONE} ls_state_t;

    ls_state_t              state;
    logic                   is_load;
    logic                   is_store;
    logic                   resp_valid;
    logic                   resp_ok;
    logic                   req_left;
    logic                   issue;
    logic [`EXU_ADDR_W-1:0] addr_q;
    logic [`EXU_STRB_W-1:0] size_mask;
    logic [`EXU_XLEN-1:0]   rdata_q;
    logic [`EXU_XLEN-1:0]   lane_data;
    logic                   sign_b;
    logic                   sign_h;
    logic                   sign_w;

    assign is_load  = mem_kind == MEM_LOAD;
    assign is_store = mem_kind == MEM_STORE;
    assign rready   = 1'b1;
    assign bready   = 1'b1;
    assign araddr   = addr_q;
    assign awaddr   = addr_q;

    // response for the current access kind
    assign resp_valid = is_load ? rvalid : bvalid;
    assign resp_ok    = (is_load ? rresp : bresp) == `EXU_RESP_OKAY;
    // some valid still waiting for its ready after this cycle
    assign req_left   = (arvalid & ~arready) | (awvalid & ~awready) | (wvalid & ~wready);
    // first request, or replay after an error response
    assign issue = (state == LS_IDLE && mem_kind != MEM_NONE) ||
                   (state == LS_WAIT && resp_valid && !resp_ok);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= LS_IDLE;
        end else begin
            case (state)
                LS_IDLE: if (issue) state <= LS_REQ;
                LS_REQ:  if (!req_left) state <= LS_WAIT;
                LS_WAIT: if (resp_valid) state <= resp_ok ? LS_DONE : LS_REQ;
                default: state <= LS_IDLE;
            endcase
        end
    end

    // aw and w rise together, each drops on its own ready
    always_ff @(posedge clk) begin
        if (rst) begin
            arvalid <= 1'b0;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
        end else if (issue) begin
            arvalid <= is_load;
            awvalid <= is_store;
            wvalid  <= is_store;
        end else begin
            if (arready) arvalid <= 1'b0;
            if (awready) awvalid <= 1'b0;
            if (wready) wvalid <= 1'b0;
        end
    end

    always_comb begin
        case (mem_size)
            SZ_B:    size_mask = 8'h01;
            SZ_H:    size_mask = 8'h03;
            SZ_W:    size_mask = 8'h0f;
            default: size_mask = 8'hff;
        endcase
    end

    // request payload latched once, a retry replays it unchanged
    always_ff @(posedge clk) begin
        if (state == LS_IDLE && issue) begin
            addr_q <= alu_result[`EXU_ADDR_W-1:0];
            wwdata <= src2 << {alu_result[2:0], 3'b000};
            wstrb  <= size_mask << alu_result[2:0];
        end
        if (state == LS_WAIT && is_load && rvalid && rready && resp_ok) begin
            rdata_q <= rrdata;
        end
    end

    // move the addressed lane down to bit 0 then extend
    assign lane_data = rdata_q >> {addr_q[2:0], 3'b000};
    assign sign_b    = ~mem_unsigned & lane_data[7];
    assign sign_h    = ~mem_unsigned & lane_data[15];
    assign sign_w    = ~mem_unsigned & lane_data[31];

    always_comb begin
        case (mem_size)
            SZ_B:    load_data = {{(`EXU_XLEN-8){sign_b}}, lane_data[7:0]};
            SZ_H:    load_data = {{(`EXU_XLEN-16){sign_h}}, lane_data[15:0]};
            SZ_W:    load_data = {{(`EXU_XLEN-32){sign_w}}, lane_data[31:0]};
            default: load_data = lane_data;
        endcase
    end

    // stall upstream until the access retires
    assign exu_block = (mem_kind != MEM_NONE) && (state != LS_DONE);
    assign load_done = (state == LS_DONE) && is_load;
    assign pc_update = op_valid && !exu_block;

endmodule

/* exu_top.sv */
`timescale 1ns/1ps
`include "exu_defs.svh"

module exu_top import exu_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  exu_op_t                opcode,
    input  logic [`EXU_XLEN-1:0]   pc,
    input  logic [`EXU_XLEN-1:0]   imm,
    input  logic [`EXU_REG_AW-1:0] rd,
    input  logic [`EXU_REG_AW-1:0] rs1,
    input  logic [`EXU_REG_AW-1:0] rs2,
    output logic [`EXU_XLEN-1:0]   dnpc,
    output logic                   pc_update,
    output logic                   exu_block,
    output logic                   arvalid,
    output logic [`EXU_ADDR_W-1:0] araddr,
    input  logic                   arready,
    input  logic                   rvalid,
    input  logic [`EXU_XLEN-1:0]   rrdata,
    input  logic [`EXU_RESP_W-1:0] rresp,
    output logic                   rready,
    output logic                   awvalid,
    output logic [`EXU_ADDR_W-1:0] awaddr,
    input  logic                   awready,
    output logic                   wvalid,
    output logic [`EXU_XLEN-1:0]   wwdata,
    output logic [`EXU_STRB_W-1:0] wstrb,
    input  logic                   wready,
    input  logic                   bvalid,
    input  logic [`EXU_RESP_W-1:0] bresp,
    output logic                   bready
);

    // register operands
    logic [`EXU_XLEN-1:0] src1;
    logic [`EXU_XLEN-1:0] src2;
    // decode to alu/branch
    logic [`EXU_XLEN-1:0] operand_a;
    logic [`EXU_XLEN-1:0] operand_b;
    alu_op_t              alu_op;
    br_cond_t             br_cond;
    // decode to lsu and writeback
    mem_kind_t            mem_kind;
    mem_size_t            mem_size;
    logic                 mem_unsigned;
    wb_sel_t              wb_sel;
    logic                 op_valid;
    // results back to the register file
    logic [`EXU_XLEN-1:0] alu_result;
    logic [`EXU_XLEN-1:0] link;
    logic [`EXU_XLEN-1:0] load_data;
    logic                 load_done;

    // all port names match the wires above
    exu_decode     u_decode     (.*);
    exu_regfile    u_regfile    (.*);
    exu_alu_branch u_alu_branch (.*);
    exu_lsu        u_lsu        (.*);

endmodule

/* exu_tb.sv */
`timescale 1ns/1ps
`include "exu_defs.svh"

module exu_tb import exu_pkg::*; ();

    localparam int CLK_PERIOD = 40;
    localparam int TIMEOUT    = 50;

    logic                   clk;
    logic                   rst;
    exu_op_t                opcode;
    logic [`EXU_XLEN-1:0]   pc;
    logic [`EXU_XLEN-1:0]   imm;
    logic [`EXU_REG_AW-1:0] rd;
    logic [`EXU_REG_AW-1:0] rs1;
    logic [`EXU_REG_AW-1:0] rs2;
    logic [`EXU_XLEN-1:0]   dnpc;
    logic                   pc_update;
    logic                   exu_block;
    logic                   arvalid;
    logic [`EXU_ADDR_W-1:0] araddr;
    logic                   arready;
    logic                   rvalid;
    logic [`EXU_XLEN-1:0]   rrdata;
    logic [`EXU_RESP_W-1:0] rresp;
    logic                   rready;
    logic                   awvalid;
    logic [`EXU_ADDR_W-1:0] awaddr;
    logic                   awready;
    logic                   wvalid;
    logic [`EXU_XLEN-1:0]   wwdata;
    logic [`EXU_STRB_W-1:0] wstrb;
    logic                   wready;
    logic                   bvalid;
    logic [`EXU_RESP_W-1:0] bresp;
    logic                   bready;

    // reference register file
    logic [`EXU_XLEN-1:0] model [`EXU_NUM_REGS];
    logic [31:0]          seed;
    int                   errors;
    int                   checks;
    int                   test_errors;

    exu_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // upper lcg bits since the low ones repeat quickly
    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = lcg_next();
        return int'(r[30:16]) % n;
    endfunction

    function automatic logic [63:0] rand64();
        return {lcg_next(), lcg_next()};
    endfunction

    // address offset bits an aligned access of this size may set
    function automatic int lane_align(input exu_op_t op);
        case (op)
            OP_SB, OP_LB, OP_LBU: return 7;
            OP_SH, OP_LH, OP_LHU: return 6;
            OP_SW, OP_LW, OP_LWU: return 4;
            default:              return 0;
        endcase
    endfunction

    function automatic logic [63:0] expect_alu(input exu_op_t op, input logic [63:0] a,
                                               input logic [63:0] b, input logic [63:0] im,
                                               input logic [63:0] p);
        case (op)
            OP_ADD:   return a + b;
            OP_SUB:   return a - b;
            OP_AND:   return a & b;
            OP_OR:    return a | b;
            OP_XOR:   return a ^ b;
            OP_SLL:   return a << b[5:0];
            OP_SRL:   return a >> b[5:0];
            OP_SRA:   return $signed(a) >>> b[5:0];
            OP_SLT:   return {63'b0, $signed(a) < $signed(b)};
            OP_SLTU:  return {63'b0, a < b};
            OP_ADDI:  return a + im;
            OP_LUI:   return im;
            OP_AUIPC: return p + im;
            default:  return 64'h0;
        endcase
    endfunction

    function automatic logic branch_taken(input exu_op_t op, input logic [63:0] a,
                                          input logic [63:0] b);
        case (op)
            OP_BEQ:  return a == b;
            OP_BNE:  return a != b;
            OP_BLT:  return $signed(a) < $signed(b);
            OP_BGE:  return $signed(a) >= $signed(b);
            OP_BLTU: return a < b;
            OP_BGEU: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // pick the addressed lane then extend it
    function automatic logic [63:0] expect_load(input exu_op_t op, input logic [63:0] word,
                                                input logic [2:0] lane);
        logic [63:0] v;
        v = word >> {lane, 3'b000};
        case (op)
            OP_LB:   return {{56{v[7]}}, v[7:0]};
            OP_LBU:  return {56'b0, v[7:0]};
            OP_LH:   return {{48{v[15]}}, v[15:0]};
            OP_LHU:  return {48'b0, v[15:0]};
            OP_LW:   return {{32{v[31]}}, v[31:0]};
            OP_LWU:  return {32'b0, v[31:0]};
            default: return v;
        endcase
    endfunction

    task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("mismatch %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("error: %s", what);
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("timeout waiting for %s", what);
        $display("TEST FAILED");
        $finish;
    endtask

    task automatic finish_test(input string name);
        $display("%s finished with %0d errors", name, errors - test_errors);
        test_errors = errors;
    endtask

    task automatic present(input exu_op_t op, input logic [4:0] d, input logic [4:0] s1,
                           input logic [4:0] s2, input logic [63:0] im, input logic [63:0] p);
        @(posedge clk);
        opcode <= op;
        rd     <= d;
        rs1    <= s1;
        rs2    <= s2;
        imm    <= im;
        pc     <= p;
    endtask

    // the register write lands on this edge
    task automatic retire();
        @(posedge clk);
        opcode <= OP_NOP;
    endtask

    // bus slave with a random ready delay and optional error responses first
    task automatic serve_mem(input logic is_load, input logic [63:0] rdata, input int n_err,
                             output logic [31:0] addr, output logic [63:0] data,
                             output logic [7:0] strb);
        int    t;
        string what;
        if (is_load) what = "arvalid";
        else what = "awvalid and wvalid";
        for (int k = 0; k <= n_err; k++) begin
            t = 0;
            @(negedge clk);
            while (!(is_load ? arvalid : (awvalid && wvalid))) begin
                if (t == TIMEOUT) stop_on_timeout(what);
                @(negedge clk);
                t++;
            end
            check_true(exu_block && !pc_update, "pc_update high while the access is open");
            if (k == 0) begin
                addr = is_load ? araddr : awaddr;
                data = wwdata;
                strb = wstrb;
            end else begin
                check_val("retry araddr", 64'(addr), 64'(araddr));
            end
            repeat (rand_below(4)) @(posedge clk);
            @(posedge clk);
            arready <= is_load;
            awready <= !is_load;
            wready  <= !is_load;
            @(negedge clk);
            check_true(is_load ? arvalid : (awvalid && wvalid), "valid dropped before ready");
            // response follows right after the handshake edge
            @(posedge clk);
            arready <= 1'b0;
            awready <= 1'b0;
            wready  <= 1'b0;
            rvalid  <= is_load;
            bvalid  <= !is_load;
            rrdata  <= (k < n_err) ? ~rdata : rdata;
            rresp   <= (k < n_err) ? 2'b10 : `EXU_RESP_OKAY;
            bresp   <= `EXU_RESP_OKAY;
            @(negedge clk);
            check_true(!pc_update && !arvalid && !awvalid,
                       "pc_update or a request valid high in the response cycle");
            check_true(is_load ? rready : bready, "ready low while the response is valid");
            @(posedge clk);
            rvalid <= 1'b0;
            bvalid <= 1'b0;
        end
        @(negedge clk);
        check_true(pc_update && !exu_block, "pc_update not raised after the response");
    endtask

    task automatic run_alu(input exu_op_t op, input logic [4:0] d, input logic [4:0] s1,
                           input logic [4:0] s2, input logic [63:0] im, input logic [63:0] p);
        logic [63:0] result;
        result = expect_alu(op, model[s1], model[s2], im, p);
        present(op, d, s1, s2, im, p);
        @(negedge clk);
        check_true(pc_update && !exu_block, "pc_update low on an alu instruction");
        check_val({op.name(), " dnpc"}, p + 64'd4, dnpc);
        retire();
        if (d != 5'd0) model[d] = result;
    endtask

    task automatic run_store(input string name, input exu_op_t op, input logic [4:0] s1,
                             input logic [4:0] s2, input logic [63:0] im);
        logic [31:0] a;
        logic [63:0] d;
        logic [7:0]  s;
        logic [63:0] exp_addr;
        logic [7:0]  exp_strb;
        logic [63:0] keep;
        exp_addr = model[s1] + im;
        exp_strb = (8'hff >> lane_align(op)) << exp_addr[2:0];
        for (int i = 0; i < 8; i++) keep[i*8 +: 8] = {8{exp_strb[i]}};
        present(op, 5'd0, s1, s2, im, 64'h0);
        serve_mem(1'b0, 64'h0, 0, a, d, s);
        retire();
        check_val({name, " awaddr"}, 64'(exp_addr[31:0]), 64'(a));
        check_val({name, " wstrb"}, 64'(exp_strb), 64'(s));
        check_val({name, " wwdata"}, (model[s2] << {exp_addr[2:0], 3'b000}) & keep, d & keep);
    endtask

    // loaded value is read back through a store
    task automatic run_load(input exu_op_t op, input logic [4:0] d, input logic [4:0] s1,
                            input logic [63:0] im, input logic [63:0] word, input int n_err);
        logic [31:0] a;
        logic [63:0] unused_data;
        logic [7:0]  unused_strb;
        logic [63:0] exp_addr;
        exp_addr = model[s1] + im;
        present(op, d, s1, 5'd0, im, 64'h0);
        serve_mem(1'b1, word, n_err, a, unused_data, unused_strb);
        retire();
        check_val({op.name(), " araddr"}, 64'(exp_addr[31:0]), 64'(a));
        if (d != 5'd0) model[d] = expect_load(op, word, exp_addr[2:0]);
        run_store({op.name(), " readback"}, OP_SD, 5'd31, d, 64'(8 * rand_below(64)));
    endtask

    // branches and jumps with the jump links observed later
    task automatic run_control(input exu_op_t op, input logic [4:0] d, input logic [4:0] s1,
                               input logic [4:0] s2, input logic [63:0] im,
                               input logic [63:0] p);
        logic [63:0] target;
        case (op)
            OP_JAL:  target = p + im;
            OP_JALR: target = (model[s1] + im) & ~64'h1;
            default: target = branch_taken(op, model[s1], model[s2]) ? p + im : p + 64'd4;
        endcase
        present(op, d, s1, s2, im, p);
        @(negedge clk);
        check_true(pc_update, "pc_update low on a control instruction");
        check_val({op.name(), " dnpc"}, target, dnpc);
        retire();
        if ((op == OP_JAL || op == OP_JALR) && d != 5'd0) model[d] = p + 64'd4;
    endtask

    initial begin
        exu_op_t     op;
        logic [63:0] v;
        logic [4:0]  dst;
        int          off;
        seed        = 32'd2450;
        errors      = 0;
        checks      = 0;
        test_errors = 0;
        rst         = 1'b1;
        opcode      = OP_NOP;
        pc          = '0;
        imm         = '0;
        rd          = '0;
        rs1         = '0;
        rs2         = '0;
        arready     = 1'b0;
        rvalid      = 1'b0;
        rrdata      = '0;
        rresp       = '0;
        awready     = 1'b0;
        wready      = 1'b0;
        bvalid      = 1'b0;
        bresp       = '0;
        for (int i = 0; i < `EXU_NUM_REGS; i++) model[i] = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        // idle after reset
        @(negedge clk);
        check_val("reset arvalid", 64'(0), 64'(arvalid));
        check_val("reset awvalid", 64'(0), 64'(awvalid));
        check_val("reset wvalid", 64'(0), 64'(wvalid));
        check_val("reset exu_block", 64'(0), 64'(exu_block));
        check_val("reset pc_update", 64'(0), 64'(pc_update));
        finish_test("reset");

        // x31 is the 8-byte aligned store base and x1..x15 are random
        v = rand64();
        run_alu(OP_LUI, 5'd31, 5'd0, 5'd0, {v[63:3], 3'b000}, 64'h0);
        for (int r = 1; r < 16; r++) run_alu(OP_LUI, 5'(r), 5'd0, 5'd0, rand64(), 64'h0);

        // every eighth result goes to x0
        for (int i = 0; i < 40; i++) begin
            op  = exu_op_t'(1 + rand_below(13));
            v   = rand64() & ~64'h3;
            dst = (i % 8 == 0) ? 5'd0 : 5'(rand_below(16));
            run_alu(op, dst, 5'(rand_below(16)), 5'(rand_below(16)), rand64(), v);
            run_store({op.name(), " result"}, OP_SD, 5'd31, dst, 64'(8 * rand_below(64)));
        end
        finish_test("alu");

        for (int i = 0; i < 24; i++) begin
            op  = exu_op_t'(OP_SB + rand_below(3));
            off = rand_below(8) & lane_align(op);
            run_store(op.name(), op, 5'd31, 5'(1 + rand_below(15)),
                      64'(8 * rand_below(32) + off));
        end
        finish_test("store lanes");

        for (int i = 0; i < 21; i++) begin
            op  = exu_op_t'(OP_LB + (i % 7));
            off = rand_below(8) & lane_align(op);
            run_load(op, 5'(1 + rand_below(15)), 5'd31, 64'(8 * rand_below(32) + off),
                     rand64(), 0);
        end
        // error response first and the replay completes
        run_load(OP_LD, 5'd9, 5'd31, 64'd16, rand64(), 1);
        finish_test("loads");

        for (int o = OP_BEQ; o <= OP_BGEU; o++) begin
            op = exu_op_t'(o);
            run_control(op, 5'd0, 5'd1, 5'd2, rand64() & ~64'h1, rand64() & ~64'h3);
            run_control(op, 5'd0, 5'd2, 5'd1, rand64() & ~64'h1, rand64() & ~64'h3);
            run_control(op, 5'd0, 5'd1, 5'd1, rand64() & ~64'h1, rand64() & ~64'h3);
        end
        run_control(OP_JAL, 5'd5, 5'd0, 5'd0, rand64() & ~64'h1, rand64() & ~64'h3);
        run_store("jal link", OP_SD, 5'd31, 5'd5, 64'd0);
        run_control(OP_JALR, 5'd6, 5'd1, 5'd0, rand64(), rand64() & ~64'h3);
        run_store("jalr link", OP_SD, 5'd31, 5'd6, 64'd8);
        finish_test("branches");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* exu_top.f */
+incdir+.
exu_pkg.sv
exu_decode.sv
exu_regfile.sv
exu_alu_branch.sv
exu_lsu.sv
exu_top.sv
exu_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := exu_tb
FILELIST  := exu_top.f
VFLAGS    := --binary --timing --assert -j 0
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST OK" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
